//--- files.f
source/exe_pkg.sv
source/half_alu.sv
source/split_regfile.sv
source/load_store_unit.sv
source/apb_scratchpad.sv
source/exe_mem_wb_stage.sv
source/exe_subsystem_top.sv
sim/tb_exe_subsystem.sv

//--- Makefile
# Verilator flow for the execute stage testbench

VERILATOR   ?= verilator
TOP         ?= tb_exe_subsystem
FILELIST    ?= files.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
WAIT_STATES ?= 1
VFLAGS      ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GWAIT_STATES=$(WAIT_STATES)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GWAIT_STATES=$(WAIT_STATES) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_exe_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exe_subsystem #(
	parameter int unsigned WAIT_STATES = 1
);

	localparam int unsigned DMEM_HALVES = 256;
	localparam int          CLK_HALF    = 4;   // 8 ns period
	localparam int          TEST_STEPS  = 240; // Strobes plus register reads, rounded up
	localparam int          MAX_OP_CYC  = 2 * (2 + WAIT_STATES) + 4;
	localparam longint      TIMEOUT_NS  = 2 * TEST_STEPS * MAX_OP_CYC * 2 * CLK_HALF;

	logic            clk;
	logic            rst_n;
	logic            issue_valid;
	exe_pkg::issue_s issue;
	logic            ready;
	logic            cmp_result;
	logic            cmp_valid;
	exe_pkg::word_t  reg32;

	exe_pkg::word_t model [32];               // Expected register file
	exe_pkg::half_t mem_model [DMEM_HALVES];  // Expected scratchpad halves
	logic [31:0]    lcg_state = 32'hd7d3_22a7;

	// Operand pairs that carry or borrow across bit 15
	exe_pkg::word_t carry_a [4] = '{32'h1234_FFFF, 32'h0000_8000, 32'h0001_0000, 32'h8000_0000};
	exe_pkg::word_t carry_b [4] = '{32'h0000_0001, 32'h0001_8000, 32'h0000_0001, 32'h0000_FFFF};

	exe_subsystem_top #(
		.DMEM_HALVES (DMEM_HALVES),
		.WAIT_STATES (WAIT_STATES)
	) dut0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.issue_valid_i (issue_valid),
		.issue_i       (issue),
		.ready_o       (ready),
		.cmp_result_o  (cmp_result),
		.cmp_valid_o   (cmp_valid),
		.reg32_o       (reg32)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// Hang guard, sized from the step count
	initial begin
		#(TIMEOUT_NS);
		stop_on_error("Watchdog expired, the DUT never came back to ready and the run hung");
	end

	// ======================================================================
	// Helpers and reference rules
	// ======================================================================
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic exe_pkg::reg_idx_t rand_reg(); // Never r0
		return exe_pkg::reg_idx_t'(1 + (next_rand() >> 16) % 31);
	endfunction

	function automatic exe_pkg::alu_op_e rand_op();
		logic [2:0] sel;
		sel = 3'((next_rand() >> 16) % 5);
		return exe_pkg::alu_op_e'(sel);
	endfunction

	function automatic exe_pkg::issue_s build_op(
		exe_pkg::exe_kind_e kind, exe_pkg::alu_op_e alu_op, exe_pkg::reg_idx_t rd,
		exe_pkg::reg_idx_t rs_a, exe_pkg::reg_idx_t rs_b, exe_pkg::word_t imm);
		exe_pkg::issue_s op;
		op.kind   = kind;
		op.alu_op = alu_op;
		op.rd     = rd;
		op.rs_a   = rs_a;
		op.rs_b   = rs_b;
		op.imm    = imm;
		return op;
	endfunction

	// Full 32-bit result of one register op
	function automatic exe_pkg::word_t alu_ref(exe_pkg::alu_op_e op, exe_pkg::word_t a,
		exe_pkg::word_t b);
		case (op)
			exe_pkg::ALU_ADD: return a + b;
			exe_pkg::ALU_SUB: return a - b;
			exe_pkg::ALU_AND: return a & b;
			exe_pkg::ALU_OR:  return a | b;
			default:          return a ^ b;
		endcase
	endfunction

	function automatic int half_index(exe_pkg::dmem_addr_t addr);
		return int'(addr >> 1) % int'(DMEM_HALVES); // Wraps at scratchpad depth
	endfunction

	function automatic void apply_model(exe_pkg::issue_s op);
		exe_pkg::word_t value;
		value = model[op.rd];
		case (op.kind)
			exe_pkg::EXE_ALU: value = alu_ref(op.alu_op, model[op.rs_a], op.imm);
			exe_pkg::EXE_IMM: value = op.imm;
			exe_pkg::EXE_LOAD: begin
				value = {mem_model[half_index(op.imm[15:0] + 16'd2)],
				         mem_model[half_index(op.imm[15:0])]};
			end
			exe_pkg::EXE_STORE: begin
				mem_model[half_index(op.imm[15:0])]         = model[op.rs_b][15:0];
				mem_model[half_index(op.imm[15:0] + 16'd2)] = model[op.rs_b][31:16];
			end
			default: value = model[op.rd]; // Compare leaves registers alone
		endcase
		if (op.rd != 5'd0)
			model[op.rd] = value;
	endfunction

	// ======================================================================
	// Checks
	// ======================================================================
	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input exe_pkg::word_t exp,
		input exe_pkg::word_t act);
		if (act !== exp)
			stop_on_error($sformatf("** Error [%s] expected %08h, actual %08h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_on_error($sformatf("** Error [%s] expected %b, actual %b", name, exp, act));
	endtask

	// ======================================================================
	// Drive tasks
	// ======================================================================
	// Strobe at this falling edge, or the first later one with ready high
	task automatic strobe_op(input exe_pkg::issue_s op);
		while (!ready)
			@(negedge clk);
		issue       = op;
		issue_valid = 1'b1;
		apply_model(op);
		@(negedge clk);
		issue_valid = 1'b0; // Edge 0 has passed here
	endtask

	// Strobe lands in the first low phase with ready high
	task automatic issue_op(input exe_pkg::issue_s op);
		@(negedge clk);
		strobe_op(op);
	endtask

	task automatic read_reg(input exe_pkg::reg_idx_t idx, output exe_pkg::word_t value);
		@(negedge clk);
		while (!ready)
			@(negedge clk);
		issue.rs_b = idx;   // 32-bit port follows rs_b
		#1;
		value = reg32;
	endtask

	task automatic verify_reg(input string name, input exe_pkg::reg_idx_t idx);
		exe_pkg::word_t value;
		read_reg(idx, value);
		check_word(name, model[idx], value);
	endtask

	// ALU or immediate op with the two busy cycles checked
	task automatic run_timed(input string name, input exe_pkg::issue_s op);
		issue_op(op);
		check_bit({name, " busy after edge 0"}, 1'b0, ready);
		@(negedge clk);
		check_bit({name, " busy after edge 1"}, 1'b0, ready);
		@(negedge clk);
		check_bit({name, " ready after edge 2"}, 1'b1, ready);
		verify_reg(name, op.rd);
	endtask

	task automatic run_compare(input string name, input exe_pkg::alu_op_e rule,
		input exe_pkg::word_t a, input exe_pkg::word_t b);
		logic expected;
		expected = (rule == exe_pkg::ALU_XOR) ? (a == b) : (a < b);
		issue_op(build_op(exe_pkg::EXE_IMM, exe_pkg::ALU_ADD, 5'd7, 5'd0, 5'd0, a));
		issue_op(build_op(exe_pkg::EXE_CMP, rule, 5'd0, 5'd7, 5'd0, b));
		check_bit({name, " valid after edge 0"}, 1'b0, cmp_valid);
		@(negedge clk);
		check_bit({name, " valid after edge 1"}, 1'b0, cmp_valid);
		@(negedge clk);
		check_bit({name, " valid after edge 2"}, 1'b1, cmp_valid);
		check_bit({name, " result"}, expected, cmp_result);
		check_bit({name, " ready with result"}, 1'b1, ready);
		@(negedge clk);
		check_bit({name, " single pulse"}, 1'b0, cmp_valid);
	endtask

	// ======================================================================
	// Tests
	// ======================================================================
	task automatic test_reset();
		check_bit("reset ready", 1'b1, ready);
		check_bit("reset cmp_valid", 1'b0, cmp_valid);
		for (int i = 0; i < 6; i++)
			verify_reg("reset register", rand_reg());
	endtask

	task automatic test_alu();
		exe_pkg::issue_s op;
		for (int r = 1; r < 32; r++)
			run_timed("imm fill", build_op(exe_pkg::EXE_IMM, exe_pkg::ALU_ADD, 5'(r),
				5'd0, 5'd0, next_rand()));
		for (int i = 0; i < 20; i++) begin
			op = build_op(exe_pkg::EXE_ALU, rand_op(), rand_reg(), rand_reg(), 5'd0, next_rand());
			if (i < 4) begin
				op.alu_op = (i < 2) ? exe_pkg::ALU_ADD : exe_pkg::ALU_SUB;
				op.imm    = carry_b[i];
				run_timed("carry seed", build_op(exe_pkg::EXE_IMM, exe_pkg::ALU_ADD, op.rs_a,
					5'd0, 5'd0, carry_a[i]));
			end
			run_timed("alu op", op);
		end
	endtask

	task automatic test_reg0();
		exe_pkg::word_t value;
		run_timed("r0 imm", build_op(exe_pkg::EXE_IMM, exe_pkg::ALU_ADD, 5'd0, 5'd0, 5'd0,
			32'hDEAD_BEEF));
		run_timed("r0 alu", build_op(exe_pkg::EXE_ALU, exe_pkg::ALU_OR, 5'd0, rand_reg(), 5'd0,
			32'hFFFF_FFFF));
		run_timed("r0 as source", build_op(exe_pkg::EXE_ALU, exe_pkg::ALU_ADD, 5'd9, 5'd0, 5'd0,
			32'h0001_2345));
		read_reg(5'd0, value);
		check_word("r0 reads zero", 32'h0, value);
	endtask

	task automatic test_store_load();
		exe_pkg::dmem_addr_t base;
		exe_pkg::word_t      words [4];
		exe_pkg::word_t      value;
		base = exe_pkg::dmem_addr_t'(next_rand() >> 16) & 16'hFFFE; // Even only
		for (int i = 0; i < 4; i++) begin
			words[i] = next_rand();
			issue_op(build_op(exe_pkg::EXE_IMM, exe_pkg::ALU_ADD, 5'(1 + i), 5'd0, 5'd0,
				words[i]));
			issue_op(build_op(exe_pkg::EXE_STORE, exe_pkg::ALU_ADD, 5'd0, 5'd0, 5'(1 + i),
				{16'h0, base + 16'(4 * i)}));
		end
		for (int i = 0; i < 4; i++) begin
			issue_op(build_op(exe_pkg::EXE_LOAD, exe_pkg::ALU_ADD, 5'(20 + i), 5'd0, 5'd0,
				{16'h0, base + 16'(4 * i)}));
			read_reg(5'(20 + i), value);
			check_word("load vs stored word", words[i], value);
			check_word("load vs model", model[20 + i], value);
		end
	endtask

	task automatic test_compare();
		exe_pkg::word_t a;
		exe_pkg::word_t pair_b [4];
		a         = next_rand();
		pair_b[0] = a;                 // Equal
		pair_b[1] = a ^ 32'h0000_0410; // Low half differs
		pair_b[2] = a ^ 32'h0200_0000; // High half differs
		pair_b[3] = next_rand();
		for (int i = 0; i < 4; i++) begin
			run_compare("cmp equal", exe_pkg::ALU_XOR, a, pair_b[i]);
			run_compare("cmp less", exe_pkg::ALU_SUB, a, pair_b[i]);
			run_compare("cmp less swapped", exe_pkg::ALU_SUB, pair_b[i], a);
		end
	endtask

	// No gaps between ops, so a lost or merged strobe shows in the model
	task automatic test_back_to_back();
		exe_pkg::dmem_addr_t addr;
		addr = 16'h0040;
		for (int i = 0; i < 6; i++) begin
			if (i == 0)
				@(negedge clk);
			// Later rounds strobe in the compare result cycle
			strobe_op(build_op(exe_pkg::EXE_IMM, exe_pkg::ALU_ADD, 5'(10 + i), 5'd0, 5'd0,
				next_rand()));
			issue_op(build_op(exe_pkg::EXE_ALU, rand_op(), 5'(16 + i), 5'(10 + i), 5'd0,
				next_rand()));
			issue_op(build_op(exe_pkg::EXE_STORE, exe_pkg::ALU_ADD, 5'd0, 5'd0, 5'(16 + i),
				{16'h0, addr}));
			issue_op(build_op(exe_pkg::EXE_LOAD, exe_pkg::ALU_ADD, 5'(24 + i), 5'd0, 5'd0,
				{16'h0, addr}));
			issue_op(build_op(exe_pkg::EXE_CMP, exe_pkg::ALU_XOR, 5'd0, 5'(16 + i), 5'd0,
				model[16 + i]));
			@(negedge clk);
			@(negedge clk);
			check_bit("back-to-back compare valid", 1'b1, cmp_valid);
			check_bit("back-to-back compare equal", 1'b1, cmp_result); // Operand is rs_a itself
			addr = addr + 16'd4;
		end
		for (int r = 0; r < 32; r++)
			verify_reg("back-to-back final", 5'(r));
	endtask

	initial begin
		rst_n       = 1'b0;
		issue_valid = 1'b0;
		issue       = '0;
		for (int r = 0; r < 32; r++)
			model[r] = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		test_reset();
		test_alu();
		test_reg0();
		test_store_load();
		test_compare();
		test_back_to_back();

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/exe_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module exe_subsystem_top #(
	parameter int unsigned DMEM_HALVES = 256,
	parameter int unsigned WAIT_STATES = 1
) (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire logic            issue_valid_i,
	input  wire exe_pkg::issue_s issue_i,
	output logic                 ready_o,
	output logic                 cmp_result_o,
	output logic                 cmp_valid_o,
	output exe_pkg::word_t       reg32_o
);

	// Stage to scratchpad bus
	exe_pkg::apb_req_s apb_req;
	exe_pkg::apb_rsp_s apb_rsp;

	exe_mem_wb_stage u_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.issue_valid_i (issue_valid_i),
		.issue_i       (issue_i),
		.apb_req_o     (apb_req),
		.apb_rsp_i     (apb_rsp),
		.ready_o       (ready_o),
		.cmp_result_o  (cmp_result_o),
		.cmp_valid_o   (cmp_valid_o),
		.reg32_o       (reg32_o)
	);

	apb_scratchpad #(
		.DMEM_HALVES (DMEM_HALVES),
		.WAIT_STATES (WAIT_STATES)
	) u_dmem (
		.clk       (clk),
		.rst_n     (rst_n),
		.apb_req_i (apb_req),
		.apb_rsp_o (apb_rsp)
	);

endmodule

`default_nettype wire

//--- source/exe_mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exe_mem_wb_stage (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              issue_valid_i, // Single-cycle strobe
	input  wire exe_pkg::issue_s   issue_i,
	output exe_pkg::apb_req_s      apb_req_o,
	input  wire exe_pkg::apb_rsp_s apb_rsp_i,
	output logic                   ready_o,
	output logic                   cmp_result_o,
	output logic                   cmp_valid_o,
	output exe_pkg::word_t         reg32_o        // Forwarding, rs_b of issue
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOW,
		ST_HIGH,
		ST_MEM
	} state_e;

	state_e          state_q;
	exe_pkg::issue_s op_q;     // Operation in flight

	logic accept;    // Strobe taken this cycle
	logic mem_kind;  // Incoming op is load or store
	logic low_half;
	logic high_half;
	logic alu_phase; // Low or high half step

	// Sub-block wires
	exe_pkg::half_t alu_result;
	exe_pkg::half_t imm_half;
	logic           cmp_less;
	logic           cmp_equal;
	exe_pkg::word_t rs32_data;
	exe_pkg::half_t rs16_data;
	logic           lsu_load_valid;
	logic           lsu_load_high;
	exe_pkg::half_t lsu_load_data;
	logic           lsu_done;

	// Write port
	logic           wb_write;
	logic           wb_high;
	exe_pkg::half_t wb_data;

	assign ready_o   = (state_q == ST_IDLE);
	assign accept    = issue_valid_i && ready_o;
	assign mem_kind  = (issue_i.kind == exe_pkg::EXE_LOAD) ||
	                   (issue_i.kind == exe_pkg::EXE_STORE);
	assign low_half  = (state_q == ST_LOW);
	assign high_half = (state_q == ST_HIGH);
	assign alu_phase = low_half || high_half;
	assign imm_half  = high_half ? op_q.imm[31:16] : op_q.imm[15:0];

	// ======================================================================
	// Sequencing
	// ======================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (accept)
						state_q <= mem_kind ? ST_MEM : ST_LOW;
				end
				ST_LOW:  state_q <= ST_HIGH;
				ST_HIGH: state_q <= ST_IDLE;
				ST_MEM: begin
					if (lsu_done)
						state_q <= ST_IDLE; // Both transfers over
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			op_q <= issue_i;
	end

	// Compare result lands the cycle after the high half
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmp_valid_o  <= 1'b0;
			cmp_result_o <= 1'b0;
		end else begin
			cmp_valid_o <= high_half && (op_q.kind == exe_pkg::EXE_CMP);
			if (high_half)
				cmp_result_o <= (op_q.alu_op == exe_pkg::ALU_XOR) ? cmp_equal : cmp_less;
		end
	end

	// ======================================================================
	// Write-back select
	// ======================================================================
	always_comb begin
		wb_write = 1'b0;
		wb_high  = high_half;
		wb_data  = alu_result;
		case (op_q.kind)
			exe_pkg::EXE_ALU: wb_write = alu_phase;
			exe_pkg::EXE_IMM: begin
				wb_write = alu_phase;
				wb_data  = imm_half;
			end
			exe_pkg::EXE_LOAD: begin
				wb_write = (state_q == ST_MEM) && lsu_load_valid;
				wb_high  = lsu_load_high;
				wb_data  = lsu_load_data;
			end
			default: wb_write = 1'b0; // Compare and store write nothing
		endcase
	end

	half_alu u_alu (
		.clk          (clk),
		.rst_n        (rst_n),
		.op_i         (op_q.alu_op),
		.first_half_i (low_half),
		.a_i          (rs16_data),
		.b_i          (imm_half),
		.result_o     (alu_result),
		.cmp_less_o   (cmp_less),
		.cmp_equal_o  (cmp_equal)
	);

	split_regfile u_regfile (
		.clk          (clk),
		.rst_n        (rst_n),
		.rs32_i       (issue_i.rs_b),   // Live index, not the captured op
		.rs16_i       (op_q.rs_a),
		.rs16_high_i  (high_half),
		.rd_i         (op_q.rd),
		.rd_high_i    (wb_high),
		.write_i      (wb_write),
		.write_data_i (wb_data),
		.rs32_data_o  (rs32_data),
		.rs16_data_o  (rs16_data)
	);

	// Store data read on the strobe cycle itself
	load_store_unit u_lsu (
		.clk          (clk),
		.rst_n        (rst_n),
		.start_i      (accept && mem_kind),
		.write_i      (issue_i.kind == exe_pkg::EXE_STORE),
		.addr_i       (issue_i.imm[15:0]),
		.store_data_i (rs32_data),
		.apb_req_o    (apb_req_o),
		.apb_rsp_i    (apb_rsp_i),
		.load_valid_o (lsu_load_valid),
		.load_high_o  (lsu_load_high),
		.load_data_o  (lsu_load_data),
		.done_o       (lsu_done)
	);

	assign reg32_o = rs32_data;

endmodule

`default_nettype wire

//--- source/apb_scratchpad.sv
`timescale 1ns/1ps
`default_nettype none

module apb_scratchpad #(
	parameter int unsigned DMEM_HALVES = 256, // Depth in half-words
	parameter int unsigned WAIT_STATES = 1    // Access cycles before pready
) (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire exe_pkg::apb_req_s apb_req_i,
	output exe_pkg::apb_rsp_s      apb_rsp_o
);

	localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
	localparam int IDX_W = $clog2(DMEM_HALVES);

	exe_pkg::half_t mem [DMEM_HALVES];

	logic [CNT_W-1:0] wait_cnt; // Access cycles already spent
	logic             access;
	logic [15:0]      half_idx;  // Byte address / 2, wrapped to depth

	assign access   = apb_req_i.psel && apb_req_i.penable;
	assign half_idx = (apb_req_i.paddr >> 1) % 16'(DMEM_HALVES);

	assign apb_rsp_o.pready = access && (wait_cnt == CNT_W'(WAIT_STATES));
	assign apb_rsp_o.prdata = mem[half_idx[IDX_W-1:0]];

	// Wait state counter, cleared outside access
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wait_cnt <= '0;
		else if (!access || apb_rsp_o.pready)
			wait_cnt <= '0;
		else
			wait_cnt <= wait_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (apb_rsp_o.pready && apb_req_i.pwrite)
			mem[half_idx[IDX_W-1:0]] <= apb_req_i.pwdata; // Write in ready cycle
	end

endmodule

`default_nettype wire

//--- source/load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                start_i,      // One-cycle kick from stage
	input  wire logic                write_i,      // 1 = store, 0 = load
	input  wire exe_pkg::dmem_addr_t addr_i,       // Byte address of low half
	input  wire exe_pkg::word_t      store_data_i,
	output exe_pkg::apb_req_s        apb_req_o,
	input  wire exe_pkg::apb_rsp_s   apb_rsp_i,
	output logic                     load_valid_o, // Load half returned this cycle
	output logic                     load_high_o,  // Which half is returned
	output exe_pkg::half_t           load_data_o,
	output logic                     done_o        // Second transfer ends
);

	typedef enum logic [1:0] {
		LS_IDLE,
		LS_SETUP,
		LS_ACCESS
	} ls_state_e;

	ls_state_e state_q;
	logic      half_q;  // 0 = low half transfer, 1 = high

	// Request latched on start
	logic                write_q;
	exe_pkg::dmem_addr_t addr_q;
	exe_pkg::word_t      data_q;

	logic xfer_end; // Final access cycle of a transfer

	assign xfer_end = (state_q == LS_ACCESS) && apb_rsp_i.pready;

	// ======================================================================
	// Transfer sequencing
	// ======================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= LS_IDLE;
			half_q  <= 1'b0;
		end else begin
			case (state_q)
				LS_IDLE: begin
					if (start_i) begin
						state_q <= LS_SETUP;
						half_q  <= 1'b0;
					end
				end
				LS_SETUP: state_q <= LS_ACCESS;
				LS_ACCESS: begin
					if (apb_rsp_i.pready) begin
						state_q <= half_q ? LS_IDLE : LS_SETUP; // High half next
						half_q  <= !half_q;
					end
				end
				default: state_q <= LS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start_i && (state_q == LS_IDLE)) begin
			write_q <= write_i;
			addr_q  <= addr_i;
			data_q  <= store_data_i;
		end
	end

	// Request held steady from setup until pready
	assign apb_req_o.psel    = (state_q != LS_IDLE);
	assign apb_req_o.penable = (state_q == LS_ACCESS);
	assign apb_req_o.pwrite  = write_q;
	assign apb_req_o.paddr   = half_q ? (addr_q + 16'd2) : addr_q;
	assign apb_req_o.pwdata  = half_q ? data_q[31:16] : data_q[15:0];

	// Load return toward write-back
	assign load_valid_o = xfer_end && !write_q;
	assign load_high_o  = half_q;
	assign load_data_o  = apb_rsp_i.prdata;
	assign done_o       = xfer_end && half_q;

endmodule

`default_nettype wire

//--- source/split_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module split_regfile (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire exe_pkg::reg_idx_t rs32_i,       // Full word read index
	input  wire exe_pkg::reg_idx_t rs16_i,       // Half read index
	input  wire logic              rs16_high_i,  // Upper half select for read
	input  wire exe_pkg::reg_idx_t rd_i,
	input  wire logic              rd_high_i,    // Upper half select for write
	input  wire logic              write_i,
	input  wire exe_pkg::half_t    write_data_i,
	output exe_pkg::word_t         rs32_data_o,
	output exe_pkg::half_t         rs16_data_o
);

	exe_pkg::word_t regs [32];

	// Register 0 is never written, stays at reset zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (write_i && (rd_i != '0)) begin
			if (rd_high_i)
				regs[rd_i][31:16] <= write_data_i;
			else
				regs[rd_i][15:0] <= write_data_i;
		end
	end

	// Combinational read ports
	assign rs32_data_o = regs[rs32_i];
	assign rs16_data_o = rs16_high_i ? regs[rs16_i][31:16] : regs[rs16_i][15:0];

endmodule

`default_nettype wire

//--- source/half_alu.sv
`timescale 1ns/1ps
`default_nettype none

module half_alu (
	input  wire logic             clk,
	input  wire logic             rst_n,
	input  wire exe_pkg::alu_op_e op_i,         // Operation for both halves
	input  wire logic             first_half_i, // High on the low half step
	input  wire exe_pkg::half_t   a_i,
	input  wire exe_pkg::half_t   b_i,
	output exe_pkg::half_t        result_o,
	output logic                  cmp_less_o,   // Valid on high half only
	output logic                  cmp_equal_o   // Valid on high half only
);

	// Flags kept from the low half
	logic carry_q;
	logic zero_q;

	logic           is_sub;
	logic           carry_in;
	exe_pkg::half_t b_eff;   // b, inverted for subtract
	logic [16:0]    sum;     // Carry out in bit 16
	logic           res_zero;

	assign is_sub = (op_i == exe_pkg::ALU_SUB);
	assign b_eff  = is_sub ? ~b_i : b_i;

	// Low half seeds the borrow, high half chains the stored carry
	assign carry_in = first_half_i ? is_sub : carry_q;
	assign sum      = {1'b0, a_i} + {1'b0, b_eff} + {16'd0, carry_in};

	always_comb begin
		case (op_i)
			exe_pkg::ALU_ADD: result_o = sum[15:0];
			exe_pkg::ALU_SUB: result_o = sum[15:0];
			exe_pkg::ALU_AND: result_o = a_i & b_i;
			exe_pkg::ALU_OR:  result_o = a_i | b_i;
			exe_pkg::ALU_XOR: result_o = a_i ^ b_i;
			default:          result_o = '0;
		endcase
	end

	// Zero result means equal halves for both sub and xor
	assign res_zero = (result_o == '0);

	// ======================================================================
	// 32-bit compare from two halves
	// ======================================================================
	// No carry out of a + ~b + 1 means a < b, unsigned
	assign cmp_less_o  = !sum[16];
	assign cmp_equal_o = zero_q && res_zero; // Both halves zero

	// Capture low half flags
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			carry_q <= 1'b0;
			zero_q  <= 1'b0;
		end else if (first_half_i) begin
			carry_q <= sum[16];
			zero_q  <= res_zero;
		end
	end

endmodule

`default_nettype wire

//--- source/exe_pkg.sv
`default_nettype none

package exe_pkg;

	// ======================================================================
	// Datapath widths
	// ======================================================================
	typedef logic [15:0] half_t;      // One half-word, native datapath
	typedef logic [31:0] word_t;      // Full register value
	typedef logic [4:0]  reg_idx_t;   // Register file index
	typedef logic [15:0] dmem_addr_t; // Byte address into scratchpad

	// Operation class
	typedef enum logic [2:0] {
		EXE_ALU,
		EXE_IMM,
		EXE_CMP,
		EXE_LOAD,
		EXE_STORE
	} exe_kind_e;

	// ALU op, also picks compare rule for EXE_CMP
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB, // Unsigned less-than on compare
		ALU_AND,
		ALU_OR,
		ALU_XOR  // Equality on compare
	} alu_op_e;

	// ======================================================================
	// Issue and APB bundles
	// ======================================================================
	typedef struct packed {
		exe_kind_e kind;
		alu_op_e   alu_op;
		reg_idx_t  rd;     // Destination
		reg_idx_t  rs_a;   // Half port operand
		reg_idx_t  rs_b;   // 32-bit port, store data
		word_t     imm;    // Operand, immediate or byte address
	} issue_s;

	typedef struct packed {
		logic       psel;
		logic       penable;
		logic       pwrite;
		dmem_addr_t paddr;
		half_t      pwdata;
	} apb_req_s;

	typedef struct packed {
		half_t prdata;
		logic  pready;
	} apb_rsp_s;

endpackage

`default_nettype wire
